//--- bench/up_asserts.sv
`timescale 1ns/1ps

module up_asserts (
   input logic clk,
   input logic nRst,
   input logic run,
   input logic retire,
   input logic halted,
   input logic mem_we
);
   int fail_count = 0;

   // instructions only finish while the host lets the core run.
   retire_in_run: assert property (@(posedge clk) disable iff (!nRst) retire |-> run)
      else begin
         $error("retire seen with run low");
         fail_count++;
      end

   // decode halts at the fetch after the last retire.
   stop_halts: assert property (@(posedge clk) disable iff (!nRst) $fell(run) |=> halted)
      else begin
         $error("core did not halt after run dropped");
         fail_count++;
      end

   // the host owns the memory whenever run is low.
   write_in_run: assert property (@(posedge clk) disable iff (!nRst) mem_we |-> run)
      else begin
         $error("core memory write with run low");
         fail_count++;
      end

endmodule

//--- include/up_tb_model.svh
`ifndef UP_TB_MODEL_SVH
`define UP_TB_MODEL_SVH

byte_t m_mem [256];
byte_t m_r [4];
byte_t m_sp;
pc_t   m_pc;
bit    m_int_en;
bit    m_in_handler;

task automatic model_reload();
   for (int i = 0; i < 4; i++) begin
      m_r[i] = m_mem[i + 1];
   end
   m_pc         = PC_RESET;
   m_sp         = SP_RESET;
   m_int_en     = 1'b0;
   m_in_handler = 1'b0;
endtask

// entry as taken at a fetch, before any instruction.
task automatic model_interrupt();
   m_mem[m_sp]  = m_pc;
   m_sp         = m_sp - 8'd1;
   m_pc         = INT_VECTOR;
   m_in_handler = 1'b1;
endtask

task automatic model_swap(input int a);
   byte_t tmp;
   tmp        = m_r[a];
   m_r[a]     = m_r[a + 1];
   m_r[a + 1] = tmp;
endtask

task automatic model_step();
   byte_t fetch;
   nib_t  op;
   fetch = m_mem[{1'b0, m_pc[7:1]} | (m_in_handler ? HANDLER_PAGE : 8'h00)];
   op    = m_pc[0] ? fetch[3:0] : fetch[7:4];
   m_pc  = m_pc + 8'd1;
   case (opcode_e'(op))
      OP_ADD:  m_r[0] = m_r[1] + m_r[2];
      OP_SUB:  m_r[0] = m_r[1] - m_r[2];
      OP_MUL:  m_r[0] = m_r[1] * m_r[2];
      OP_NAND: m_r[0] = ~(m_r[1] & m_r[2]);
      OP_SW01: model_swap(0);
      OP_SW12: model_swap(1);
      OP_SW23: model_swap(2);
      OP_BE:   if (m_r[1] == m_r[2]) m_pc = m_r[3];
      OP_POPC: begin
         m_sp         = m_sp + 8'd1;
         m_pc         = m_mem[m_sp];
         m_in_handler = 1'b0;
      end
      OP_PUSHC: begin
         m_mem[m_sp] = m_pc - 8'd1;
         m_sp        = m_sp - 8'd1;
      end
      OP_POP: begin
         m_sp   = m_sp + 8'd1;
         m_r[2] = m_mem[m_sp];
      end
      OP_PUSH: begin
         m_mem[m_sp] = m_r[2];
         m_sp        = m_sp - 8'd1;
      end
      OP_LDW:  m_r[2] = m_mem[m_r[3]];
      OP_STW:  m_mem[m_r[3]] = m_r[2];
      OP_REF:  m_r[0] = m_mem[0];
      OP_INT:  m_int_en = ~m_int_en;
   endcase
endtask

task automatic model_run(input int budget);
   for (int n = 0; n < budget; n++) begin
      model_step();
   end
endtask

`endif

//--- bench/up_tb.sv
`timescale 1ns/1ps

module up_tb;
   import up_pkg::*;

   localparam int RUNS           = 4;
   localparam int MAX_BUDGET     = 64;
   localparam int LONG_BUDGET    = 200;
   localparam int HANDLER_BUDGET = 4;
   localparam int BUDGET_SUM     = RUNS * 2 * MAX_BUDGET + LONG_BUDGET + 1 + HANDLER_BUDGET;
   // loads, polls and readback per run, three cycles each.
   localparam int XFERS          = (RUNS * 2 + 3) * 600;
   localparam int CYCLE_LIMIT    = 5 * BUDGET_SUM + 3 * XFERS + 100;

   logic        clk = 1'b0;
   logic        nRst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [8:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        int_line;
   logic [31:0] lfsr = 32'h22f3;
   int          cycles = 0;
   int          checks = 0;
   int          errors = 0;
   int          test_errs = 0;
   string       reg_names [6] = '{"r0", "r1", "r2", "r3", "sp", "pc"};

   `include "up_tb_model.svh"

   up_top UUT (.*);

   bind up_decode up_asserts decode_chk (
      .clk, .nRst, .run, .retire, .halted, .mem_we(ctrl.mem_we)
   );
   bind up_host_port up_asserts host_chk (
      .clk, .nRst, .run, .retire, .halted, .mem_we
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   // fibonacci lfsr, taps 32 22 2 1.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   task automatic apb_xfer(input logic wr, input logic [8:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      #2;
      rdata = prdata;
      err   = pslverr;
      checks++;
      if (pready !== 1'b1) begin
         errors++;
         $display("pready was not high in the access phase");
      end
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic write_mem(input byte_t addr, input byte_t data);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b1, {1'b0, addr}, {24'h0, data}, rdata, err);
      check_val("pslverr", err, 0);
   endtask

   task automatic load_memory();
      for (int a = 0; a < 256; a++) begin
         m_mem[a] = byte_t'(take_bits(8));
         write_mem(byte_t'(a), m_mem[a]);
      end
   endtask

   task automatic start_run(input logic reload, input int budget);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b1, CTRL_ADDR, {16'h0, byte_t'(budget), 6'b0, reload, 1'b1}, rdata, err);
      check_val("pslverr", err, 0);
   endtask

   task automatic wait_done();
      logic [31:0] rdata;
      logic        err;
      rdata = '0;
      while (rdata[1] !== 1'b1) begin
         apb_xfer(1'b0, STAT_ADDR, 32'h0, rdata, err);
      end
   endtask

   task automatic compare_state();
      logic [31:0] rdata;
      logic        err;
      byte_t       exp_regs [6];
      exp_regs = '{m_r[0], m_r[1], m_r[2], m_r[3], m_sp, m_pc};
      apb_xfer(1'b0, STAT_ADDR, 32'h0, rdata, err);
      check_val("status", rdata, {29'h0, m_int_en, 2'b10});
      for (int i = 0; i < 6; i++) begin
         apb_xfer(1'b0, REG_BASE + 9'(i), 32'h0, rdata, err);
         check_val(reg_names[i], rdata, exp_regs[i]);
      end
      for (int a = 0; a < 256; a++) begin
         apb_xfer(1'b0, 9'(a), 32'h0, rdata, err);
         check_val($sformatf("mem[%02h]", a), rdata, m_mem[a]);
      end
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d errors", name, errors - test_errs);
      test_errs = errors;
   endtask

   initial begin
      logic [31:0] rdata;
      logic        err;
      int          budget;
      nib_t        hi;
      nib_t        lo;
      nRst     = 1'b0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      int_line = 1'b0;
      repeat (4) @(posedge clk);
      #1 nRst = 1'b1;

      apb_xfer(1'b0, STAT_ADDR, 32'h0, rdata, err);
      check_val("status", rdata, 32'h0);
      for (int i = 0; i < 6; i++) begin
         apb_xfer(1'b0, REG_BASE + 9'(i), 32'h0, rdata, err);
         check_val(reg_names[i], rdata, (i == 4) ? 8'hFF : (i == 5) ? 8'h08 : 8'h00);
      end
      end_test("reset values");

      for (int r = 0; r < RUNS; r++) begin
         load_memory();
         budget = (r == 0) ? LONG_BUDGET : int'(take_bits(6)) + 1;
         start_run(1'b1, budget);
         model_reload();
         model_run(budget);
         if (r == 0) begin
            apb_xfer(1'b1, 9'h010, {24'h0, ~m_mem[8'h10]}, rdata, err);
            checks++;
            if (err !== 1'b1) begin
               errors++;
               $display("memory write during a run was not refused with pslverr");
            end
         end
         wait_done();
         compare_state();
         end_test($sformatf("reload run %0d, budget %0d", r, budget));

         budget = int'(take_bits(6)) + 1;
         start_run(1'b0, budget);
         model_run(budget);
         wait_done();
         compare_state();
         end_test($sformatf("chained run %0d, budget %0d", r, budget));
      end

      // INT sits at the first fetch after reload, handler at 0x80.
      load_memory();
      m_mem[4] = {4'hF, m_mem[4][3:0]};
      write_mem(8'h04, m_mem[4]);
      for (int a = 8'h80; a < 8'h82; a++) begin
         hi       = nib_t'(take_bits(3) % 7);
         lo       = nib_t'(take_bits(3) % 7);
         m_mem[a] = {hi, lo};
         write_mem(byte_t'(a), m_mem[a]);
      end
      start_run(1'b1, 1);
      model_reload();
      model_run(1);
      wait_done();
      apb_xfer(1'b0, STAT_ADDR, 32'h0, rdata, err);
      check_val("status", rdata, 32'h6);
      @(posedge clk);
      #1 int_line = 1'b1;
      repeat (2) @(posedge clk);
      start_run(1'b0, HANDLER_BUDGET);
      model_interrupt();
      model_run(HANDLER_BUDGET);
      wait_done();
      apb_xfer(1'b0, 9'h0FF, 32'h0, rdata, err);
      check_val("mem[ff]", rdata, 8'h09);
      apb_xfer(1'b0, REG_BASE + 9'd4, 32'h0, rdata, err);
      check_val("sp", rdata, 8'hFE);
      compare_state();
      int_line = 1'b0;
      end_test("interrupt");

      errors = errors + UUT.u_decode.decode_chk.fail_count
                      + UUT.u_host_port.host_chk.fail_count;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- logic/up_decode.sv
`timescale 1ns/1ps

module up_decode (
   input  logic             clk,
   input  logic             nRst,
   input  logic             run,
   input  logic             reload_req,
   input  logic             int_line,
   input  up_pkg::nib_t     ir,
   input  up_pkg::up_regs_t regs,
   output up_pkg::up_ctrl_t ctrl,
   output logic             retire,
   output logic             halted,
   output logic             in_handler,
   output logic             int_enabled
);
   import up_pkg::*;

   state_e     state;
   state_e     state_nxt;
   opcode_e    op;
   logic       z;
   logic       int_last;
   logic       int_pend;
   logic       int_go;
   logic       reload_go;
   logic [2:0] load_idx;
   logic [1:0] swap_base;
   res_sel_e   swap_sel;

   assign op        = opcode_e'(ir);
   assign z         = (regs.r1 == regs.r2);
   assign int_go    = int_pend & int_enabled & ~in_handler;
   assign reload_go = (state == HALT) & run & reload_req;
   assign halted    = (state == HALT);
   assign retire    = (state inside {EXEC_1, EXEC_2, EXEC_3}) && (state_nxt == FETCH);

   // swap steps alternate between the lower and upper register of the pair.
   assign load_idx  = 3'(state - LOAD_0);
   assign swap_base = 2'(ir - OP_SW01);
   assign swap_sel  = (op == OP_SW01) ? RS_X01 : (op == OP_SW12) ? RS_X12 : RS_X23;

   always_comb begin
      state_nxt = state;
      case (state)
         HALT:
            if (run) state_nxt = reload_req ? LOAD_0 : FETCH;
         LOAD_0, LOAD_1, LOAD_2, LOAD_3, INT_1, INT_2, INT_3:
            state_nxt = state_e'(state + 1);
         LOAD_4, INT_4, EXEC_3:
            state_nxt = FETCH;
         FETCH:
            if (!run) state_nxt = HALT;
            else if (int_go) state_nxt = INT_1;
            else state_nxt = DECODE;
         DECODE:
            state_nxt = EXEC_1;
         EXEC_1:
            if (op inside {OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_BE, OP_INT}) state_nxt = FETCH;
            else state_nxt = EXEC_2;
         EXEC_2:
            if (op inside {OP_SW01, OP_SW12, OP_SW23, OP_PUSH, OP_PUSHC}) state_nxt = EXEC_3;
            else state_nxt = FETCH;
         default:
            state_nxt = HALT;
      endcase
   end

   always_comb begin
      ctrl = '0;
      ctrl.res_sel = RS_ZERO;
      case (state)
         LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4: begin
            // r0..r3 come from bytes 1..4.
            if (state != LOAD_4) begin
               ctrl.res_sel    = RS_CONST;
               ctrl.const_addr = load_idx + 3'd1;
               ctrl.ale        = 1'b1;
            end
            if (state != LOAD_0) begin
               ctrl.rb_we      = 1'b1;
               ctrl.rb_src_mem = 1'b1;
               ctrl.rb_idx     = 2'(load_idx - 3'd1);
            end
         end
         FETCH: begin
            ctrl.res_sel = RS_FETCH;
            ctrl.ale     = 1'b1;
         end
         DECODE: begin
            ctrl.res_sel = RS_PC_P1;
            ctrl.ir_we   = 1'b1;
            ctrl.pc_we   = 1'b1;
         end
         EXEC_1:
            case (op)
               OP_ADD, OP_SUB, OP_MUL, OP_NAND: begin
                  ctrl.res_sel = res_sel_e'(RS_ADD + ir);
                  ctrl.rb_we   = 1'b1;
               end
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.res_sel = swap_sel;
                  ctrl.rb_we   = 1'b1;
                  ctrl.rb_idx  = swap_base;
               end
               OP_BE: begin
                  ctrl.res_sel = RS_R3;
                  ctrl.pc_we   = z;
               end
               OP_POP, OP_POPC: begin
                  ctrl.res_sel = RS_SP_P1;
                  ctrl.sp_we   = 1'b1;
                  ctrl.ale     = 1'b1;
               end
               OP_PUSH, OP_PUSHC: begin
                  ctrl.res_sel = RS_SP;
                  ctrl.ale     = 1'b1;
               end
               OP_LDW, OP_STW: begin
                  ctrl.res_sel = RS_R3;
                  ctrl.ale     = 1'b1;
               end
               OP_REF: begin
                  ctrl.res_sel = RS_CONST;
                  ctrl.ale     = 1'b1;
               end
               default: ;
            endcase
         EXEC_2:
            case (op)
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.res_sel = swap_sel;
                  ctrl.rb_we   = 1'b1;
                  ctrl.rb_idx  = swap_base + 2'd1;
               end
               OP_POPC: begin
                  ctrl.res_sel = RS_MEM;
                  ctrl.pc_we   = 1'b1;
               end
               OP_PUSH, OP_PUSHC: begin
                  ctrl.res_sel = RS_SP_M1;
                  ctrl.sp_we   = 1'b1;
               end
               OP_POP, OP_LDW, OP_REF: begin
                  ctrl.rb_we      = 1'b1;
                  ctrl.rb_src_mem = 1'b1;
                  ctrl.rb_idx     = (op == OP_REF) ? 2'd0 : 2'd2;
               end
               OP_STW: begin
                  ctrl.res_sel = RS_R2;
                  ctrl.mem_we  = 1'b1;
               end
               default: ;
            endcase
         EXEC_3:
            if (op == OP_PUSH || op == OP_PUSHC) begin
               ctrl.res_sel = (op == OP_PUSH) ? RS_R2 : RS_PC_M1;
               ctrl.mem_we  = 1'b1;
            end else begin
               ctrl.res_sel = swap_sel;
               ctrl.rb_we   = 1'b1;
               ctrl.rb_idx  = swap_base;
            end
         // push pc, then vector.
         INT_1: begin
            ctrl.res_sel = RS_SP;
            ctrl.ale     = 1'b1;
         end
         INT_2: begin
            ctrl.res_sel = RS_PC;
            ctrl.mem_we  = 1'b1;
         end
         INT_3: begin
            ctrl.res_sel = RS_SP_M1;
            ctrl.sp_we   = 1'b1;
         end
         INT_4: begin
            ctrl.res_sel = RS_VECTOR;
            ctrl.pc_we   = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state       <= HALT;
         int_last    <= 1'b0;
         int_pend    <= 1'b0;
         in_handler  <= 1'b0;
         int_enabled <= 1'b0;
      end else begin
         state    <= state_nxt;
         int_last <= int_line;
         if (reload_go || state_nxt == INT_1) int_pend <= 1'b0;
         else if (int_line && !int_last) int_pend <= 1'b1;
         if (reload_go || (state == EXEC_1 && op == OP_POPC)) in_handler <= 1'b0;
         else if (state == INT_1) in_handler <= 1'b1;
         if (reload_go) int_enabled <= 1'b0;
         else if (state == EXEC_1 && op == OP_INT) int_enabled <= ~int_enabled;
      end
   end

endmodule

//--- logic/up_execute.sv
`timescale 1ns/1ps

module up_execute (
   input  up_pkg::up_ctrl_t ctrl,
   input  up_pkg::up_regs_t regs,
   input  logic             in_handler,
   input  up_pkg::byte_t    mem_rdata,
   output up_pkg::byte_t    result
);
   import up_pkg::*;

   byte_t fetch_addr;

   // handler code lives in the upper half.
   assign fetch_addr = {1'b0, regs.pc[7:1]} | (in_handler ? HANDLER_PAGE : 8'h00);

   always_comb begin
      case (ctrl.res_sel)
         RS_CONST:  result = byte_t'(ctrl.const_addr);
         RS_PC_P1:  result = regs.pc + 8'd1;
         RS_PC_M1:  result = regs.pc - 8'd1;
         RS_PC:     result = regs.pc;
         RS_SP_P1:  result = regs.sp + 8'd1;
         RS_SP_M1:  result = regs.sp - 8'd1;
         RS_SP:     result = regs.sp;
         RS_ADD:    result = regs.r1 + regs.r2;
         RS_SUB:    result = regs.r1 - regs.r2;
         // low byte of the product only.
         RS_MUL:    result = regs.r1 * regs.r2;
         RS_NAND:   result = ~(regs.r1 & regs.r2);
         RS_X01:    result = regs.r0 ^ regs.r1;
         RS_X12:    result = regs.r1 ^ regs.r2;
         RS_X23:    result = regs.r2 ^ regs.r3;
         RS_R2:     result = regs.r2;
         RS_R3:     result = regs.r3;
         RS_MEM:    result = mem_rdata;
         RS_FETCH:  result = fetch_addr;
         RS_VECTOR: result = INT_VECTOR;
         default:   result = '0;
      endcase
   end

endmodule

//--- logic/up_host_port.sv
`timescale 1ns/1ps

module up_host_port (
   input  logic             clk,
   input  logic             nRst,
   input  logic             psel,
   input  logic             penable,
   input  logic             pwrite,
   input  logic [8:0]       paddr,
   input  logic [31:0]      pwdata,
   output logic [31:0]      prdata,
   output logic             pready,
   output logic             pslverr,
   output logic             run,
   output logic             reload_req,
   input  logic             retire,
   input  logic             halted,
   input  logic             int_enabled,
   input  up_pkg::up_regs_t regs,
   input  up_pkg::byte_t    mem_addr,
   input  logic             mem_we,
   input  up_pkg::byte_t    mem_wdata,
   output up_pkg::byte_t    mem_rdata
);
   import up_pkg::*;

   byte_t      mem [MEM_SIZE];
   byte_t      budget;
   byte_t      count;
   byte_t      count_nxt;
   byte_t      reg_rdata;
   logic [2:0] reg_idx;
   logic       reload_flag;
   logic       done;
   logic       access;
   logic       running;
   logic       mem_hit;
   logic       reg_hit;
   logic       ctrl_hit;
   logic       stat_hit;
   logic       ctrl_wr;

   assign access    = psel & penable;
   // the core still finishes its last fetch after run drops.
   assign running   = run | ~halted;
   assign mem_hit   = (paddr < MEM_BASE + MEM_SIZE);
   assign ctrl_hit  = (paddr == CTRL_ADDR);
   assign stat_hit  = (paddr == STAT_ADDR);
   assign reg_hit   = (paddr >= REG_BASE) && (paddr < REG_BASE + REG_COUNT);
   assign reg_idx   = 3'(paddr - REG_BASE);
   assign ctrl_wr   = access & pwrite & ctrl_hit & ~running;
   assign count_nxt = count + 8'd1;
   assign pready    = 1'b1;
   assign mem_rdata = mem[mem_addr];

   assign pslverr = access & (~(mem_hit | reg_hit | ctrl_hit | stat_hit) |
                    (running & (mem_hit | reg_hit | (ctrl_hit & pwrite & pwdata[0]))));

   always_comb begin
      case (reg_idx)
         3'd0:    reg_rdata = regs.r0;
         3'd1:    reg_rdata = regs.r1;
         3'd2:    reg_rdata = regs.r2;
         3'd3:    reg_rdata = regs.r3;
         3'd4:    reg_rdata = regs.sp;
         default: reg_rdata = regs.pc;
      endcase
   end

   always_comb begin
      prdata = '0;
      if (mem_hit) prdata[7:0] = mem[paddr[7:0]];
      else if (ctrl_hit) prdata[15:0] = {budget, 6'b0, reload_flag, 1'b0};
      else if (stat_hit) prdata[2:0] = {int_enabled, done & halted, running};
      else if (reg_hit) prdata[7:0] = reg_rdata;
   end

   // host and core never write in the same cycle.
   always_ff @(posedge clk) begin
      if (mem_we) mem[mem_addr] <= mem_wdata;
      else if (access && pwrite && mem_hit && !running) mem[paddr[7:0]] <= pwdata[7:0];
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         run         <= 1'b0;
         reload_req  <= 1'b0;
         reload_flag <= 1'b0;
         done        <= 1'b0;
         budget      <= '0;
         count       <= '0;
      end else begin
         reload_req <= 1'b0;
         if (ctrl_wr) begin
            reload_flag <= pwdata[1];
            budget      <= pwdata[15:8];
            if (pwdata[0]) begin
               count      <= '0;
               done       <= (pwdata[15:8] == 8'h00);
               run        <= (pwdata[15:8] != 8'h00);
               reload_req <= pwdata[1] && (pwdata[15:8] != 8'h00);
            end
         end else if (run && retire) begin
            count <= count_nxt;
            if (count_nxt == budget) begin
               run  <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

endmodule

//--- logic/up_pkg.sv
package up_pkg;

   typedef logic [7:0] byte_t;
   typedef logic [3:0] nib_t;
   // nibble address, fetch byte is pc >> 1.
   typedef logic [7:0] pc_t;

   typedef enum logic [3:0] {
      OP_ADD,  OP_SUB,   OP_MUL,  OP_NAND,
      OP_SW01, OP_SW12,  OP_SW23, OP_BE,
      OP_POPC, OP_PUSHC, OP_POP,  OP_PUSH,
      OP_LDW,  OP_STW,   OP_REF,  OP_INT
   } opcode_e;

   typedef enum logic [3:0] {
      HALT,
      LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4,
      FETCH, DECODE,
      EXEC_1, EXEC_2, EXEC_3,
      INT_1, INT_2, INT_3, INT_4
   } state_e;

   typedef enum logic [4:0] {
      RS_CONST, RS_PC_P1, RS_PC_M1, RS_PC, RS_SP_P1, RS_SP_M1, RS_SP,
      RS_ADD, RS_SUB, RS_MUL, RS_NAND,
      RS_X01, RS_X12, RS_X23,
      RS_R2, RS_R3, RS_MEM, RS_FETCH, RS_VECTOR, RS_ZERO
   } res_sel_e;

   typedef struct packed {
      res_sel_e   res_sel;
      logic [2:0] const_addr;
      logic       ir_we;
      logic       pc_we;
      logic       sp_we;
      logic       rb_we;
      logic       rb_src_mem;
      logic [1:0] rb_idx;
      logic       ale;
      logic       mem_we;
   } up_ctrl_t;

   typedef struct packed {
      byte_t r0;
      byte_t r1;
      byte_t r2;
      byte_t r3;
      byte_t sp;
      pc_t   pc;
   } up_regs_t;

   // apb map.
   localparam logic [8:0] MEM_BASE  = 9'h000;
   localparam int         MEM_SIZE  = 256;
   localparam logic [8:0] CTRL_ADDR = 9'h100;
   localparam logic [8:0] STAT_ADDR = 9'h101;
   localparam logic [8:0] REG_BASE  = 9'h104;
   localparam int         REG_COUNT = 6;

   localparam pc_t   PC_RESET     = 8'h08;
   localparam byte_t SP_RESET     = 8'hFF;
   localparam pc_t   INT_VECTOR   = 8'h00;
   localparam byte_t HANDLER_PAGE = 8'h80;

endpackage

//--- logic/up_result.sv
`timescale 1ns/1ps

module up_result (
   input  logic             clk,
   input  logic             nRst,
   input  up_pkg::up_ctrl_t ctrl,
   input  up_pkg::byte_t    result,
   input  up_pkg::byte_t    mem_rdata,
   input  logic             reload_req,
   output up_pkg::up_regs_t regs,
   output up_pkg::nib_t     ir,
   output up_pkg::byte_t    mem_addr,
   output logic             mem_we
);
   import up_pkg::*;

   byte_t rb_data;

   assign rb_data = ctrl.rb_src_mem ? mem_rdata : result;
   assign mem_we  = ctrl.mem_we;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs     <= '{sp: SP_RESET, pc: PC_RESET, default: '0};
         ir       <= OP_ADD;
         mem_addr <= '0;
      end else begin
         // reload only arrives while halted.
         if (reload_req) begin
            regs.pc <= PC_RESET;
            regs.sp <= SP_RESET;
         end else begin
            if (ctrl.pc_we) regs.pc <= result;
            if (ctrl.sp_we) regs.sp <= result;
         end
         if (ctrl.rb_we) begin
            case (ctrl.rb_idx)
               2'd0: regs.r0 <= rb_data;
               2'd1: regs.r1 <= rb_data;
               2'd2: regs.r2 <= rb_data;
               2'd3: regs.r3 <= rb_data;
            endcase
         end
         // even pc takes the high nibble.
         if (ctrl.ir_we) ir <= regs.pc[0] ? mem_rdata[3:0] : mem_rdata[7:4];
         if (ctrl.ale) mem_addr <= result;
      end
   end

endmodule

//--- logic/up_top.sv
`timescale 1ns/1ps

module up_top (
   input  logic        clk,
   input  logic        nRst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [8:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  logic        int_line
);
   import up_pkg::*;

   up_ctrl_t ctrl;
   up_regs_t regs;
   nib_t     ir;
   byte_t    result;
   byte_t    mem_addr;
   byte_t    mem_rdata;
   logic     mem_we;
   logic     run;
   logic     reload_req;
   logic     retire;
   logic     halted;
   logic     in_handler;
   logic     int_enabled;

   up_decode u_decode (
      .clk, .nRst, .run, .reload_req, .int_line, .ir, .regs,
      .ctrl, .retire, .halted, .in_handler, .int_enabled
   );

   up_execute u_execute (
      .ctrl, .regs, .in_handler, .mem_rdata, .result
   );

   up_result u_result (
      .clk, .nRst, .ctrl, .result, .mem_rdata, .reload_req,
      .regs, .ir, .mem_addr, .mem_we
   );

   up_host_port u_host_port (
      .clk, .nRst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
      .run, .reload_req, .retire, .halted, .int_enabled, .regs,
      .mem_addr, .mem_we, .mem_wdata(result), .mem_rdata
   );

endmodule

//--- up_top.f
+incdir+include
logic/up_pkg.sv
logic/up_decode.sv
logic/up_execute.sv
logic/up_result.sv
logic/up_host_port.sv
logic/up_top.sv
bench/up_asserts.sv
bench/up_tb.sv
